//--- verilog/sdmac_pkg.sv
// SCSI DMA controller package with register offsets, bus widths, enums and packed structs
`default_nettype none

package sdmac_pkg;

  // Bus widths
  localparam int addr_w = 8;
  localparam int data_w = 32;

  // Register offsets
  localparam logic [addr_w-1:0] off_dawr    = 8'h00;
  localparam logic [addr_w-1:0] off_wtc     = 8'h04;
  localparam logic [addr_w-1:0] off_cntr    = 8'h08;
  localparam logic [addr_w-1:0] off_acr     = 8'h0C;
  localparam logic [addr_w-1:0] off_istr    = 8'h1C;

  // Action offsets, any access here fires the action
  localparam logic [addr_w-1:0] off_st_dma  = 8'h10;
  localparam logic [addr_w-1:0] off_flush   = 8'h14;
  localparam logic [addr_w-1:0] off_cint    = 8'h18;
  localparam logic [addr_w-1:0] off_sp_dma  = 8'h3C;

  // First offset handed to the SCSI chip
  localparam logic [addr_w-1:0] off_wd_base = 8'h40;

  // Register addressed by one access
  typedef enum logic [2:0] {
    sel_none,
    sel_dawr,
    sel_wtc,
    sel_cntr,
    sel_acr,
    sel_istr
  } reg_sel_e;

  // Action opcode of one access
  typedef enum logic [2:0] {
    act_none,
    act_start,
    act_flush,
    act_clr_int,
    act_stop
  } action_e;

  // DMA controller states
  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_done
  } dma_state_e;

  // One CPU access, rw high means read as on the 68000
  typedef struct packed {
    logic              strobe;
    logic              rw;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
  } bus_req_t;

  // Decode result
  typedef struct packed {
    reg_sel_e          sel;
    action_e           act;
    logic              wr;
    logic              rd;
    logic              wd_req;
    logic [data_w-1:0] wdata;
  } dec_t;

  // Control register, dmadir set means SCSI to memory
  typedef struct packed {
    logic       dmadir;
    logic       intena;
    logic [5:0] reserved;
  } cntr_t;

  // Interrupt status register
  typedef struct packed {
    logic       int_p;
    logic       dma_run;
    logic       tc;
    logic       fe_flg;
    logic [3:0] reserved;
  } istr_t;

endpackage

`default_nettype wire

//--- verilog/sdmac_addr_decoder.sv
// SDMAC address decoder turning a CPU access into a register select, an action or a SCSI chip select
`timescale 1ns/100ps
`default_nettype none

module sdmac_addr_decoder
  import sdmac_pkg::*;
(
  input  bus_req_t req,
  output dec_t     dec,
  output logic     wd_cs
);

  logic     valid;
  logic     wd_hit;
  reg_sel_e sel;
  action_e  act;

  // Access only counts while the strobe is up
  assign valid  = req.strobe;

  // Upper window belongs to the SCSI chip
  assign wd_hit = valid && (req.addr >= off_wd_base);

  always_comb begin
    sel = sel_none;
    act = act_none;
    if (valid && !wd_hit) begin
      case (req.addr)
        // Registers
        off_dawr:   sel = sel_dawr;
        off_wtc:    sel = sel_wtc;
        off_cntr:   sel = sel_cntr;
        off_acr:    sel = sel_acr;
        off_istr:   sel = sel_istr;
        // Actions fire on read or write alike
        off_st_dma: act = act_start;
        off_flush:  act = act_flush;
        off_cint:   act = act_clr_int;
        off_sp_dma: act = act_stop;
        default:    ;
      endcase
    end
  end

  always_comb begin
    dec.sel    = sel;
    dec.act    = act;
    // Writes only land on a selected register
    dec.wr     = valid && !req.rw && (sel != sel_none);
    // Any read below the SCSI window completes, unused offsets return 0
    dec.rd     = valid && req.rw && !wd_hit;
    dec.wd_req = wd_hit;
    dec.wdata  = req.wdata;
  end

  // Chip select for the SCSI chip in the strobe cycle
  assign wd_cs = wd_hit;

  // One offset is either a register or an action
  always_comb begin
    assert final (!((sel != sel_none) && (act != act_none)))
      else $error("register select and action decoded together");
  end

endmodule

`default_nettype wire

//--- verilog/sdmac_regs.sv
// SDMAC configuration registers with CPU write logic and registered read data
`timescale 1ns/100ps
`default_nettype none

module sdmac_regs
  import sdmac_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  dec_t              dec,
  input  istr_t             status,
  input  logic [data_w-1:0] cur_addr,
  input  logic [data_w-1:0] cur_count,
  input  logic              started,
  output cntr_t             cfg_cntr,
  output logic [data_w-1:0] cfg_acr,
  output logic [data_w-1:0] cfg_wtc,
  output logic [data_w-1:0] rdata,
  output logic              rd_valid
);

  cntr_t             cntr_q;
  logic [1:0]        dawr_q;
  logic [data_w-1:0] acr_q;
  logic [data_w-1:0] wtc_q;
  logic [data_w-1:0] rd_mux;

  // Configuration writes take effect at the strobe edge
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cntr_q <= '0;
      dawr_q <= '0;
      acr_q  <= '0;
      wtc_q  <= '0;
    end else if (dec.wr) begin
      case (dec.sel)
        sel_cntr: cntr_q <= cntr_t'(dec.wdata[7:0]);
        // SCSI side width flag
        sel_dawr: dawr_q <= dec.wdata[1:0];
        sel_acr:  acr_q  <= dec.wdata;
        sel_wtc:  wtc_q  <= dec.wdata;
        // ISTR is read only
        default:  ;
      endcase
    end
  end

  // Read source selection
  always_comb begin
    case (dec.sel)
      sel_dawr: rd_mux = {{(data_w-2){1'b0}}, dawr_q};
      sel_cntr: rd_mux = {{(data_w-8){1'b0}}, cntr_q};
      // Working values replace the configured ones once a start was seen
      sel_acr:  rd_mux = started ? cur_addr : acr_q;
      sel_wtc:  rd_mux = started ? cur_count : wtc_q;
      // Status read has no side effects
      sel_istr: rd_mux = {{(data_w-8){1'b0}}, status};
      default:  rd_mux = '0;
    endcase
  end

  // Read data lands one cycle after the strobe
  always_ff @(posedge clk) begin
    if (dec.rd) begin
      rdata <= rd_mux;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= dec.rd;
    end
  end

  // Configuration seen by the DMA controller
  assign cfg_cntr = cntr_q;
  assign cfg_acr  = acr_q;
  assign cfg_wtc  = wtc_q;

  // No read data follows a write access
  assert property (@(posedge clk) disable iff (!rst_n)
    dec.wr |=> !rd_valid)
    else $error("rd_valid after a write");

  // SCSI window accesses never touch our registers
  assert property (@(posedge clk) disable iff (!rst_n)
    dec.wd_req |=> ($stable(cntr_q) && $stable(dawr_q) && $stable(acr_q) && $stable(wtc_q)))
    else $error("register changed on a SCSI chip access");

endmodule

`default_nettype wire

//--- verilog/sdmac_dma_ctrl.sv
// SDMAC DMA controller with working address and count, interrupt status and flush pulse
`timescale 1ns/100ps
`default_nettype none

module sdmac_dma_ctrl
  import sdmac_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  action_e           act,
  input  cntr_t             cfg_cntr,
  input  logic [data_w-1:0] cfg_acr,
  input  logic [data_w-1:0] cfg_wtc,
  input  logic              scsi_dreq,
  output istr_t             status,
  output logic [data_w-1:0] cur_addr,
  output logic [data_w-1:0] cur_count,
  output logic              started,
  output logic              dma_ack,
  output logic              irq,
  output logic              flush
);

  dma_state_e state;
  logic       int_p;
  logic       tc;
  logic       fe_flg;
  logic       dreq_take;
  logic       last_word;

  // Start and stop win over a data request in the same cycle
  assign dreq_take = (state == st_run) && scsi_dreq &&
                     (act != act_start) && (act != act_stop);

  // Request that brings the count to zero
  assign last_word = dreq_take && (cur_count == 32'd1);

  // Working address and count
  always_ff @(posedge clk) begin
    if (act == act_start) begin
      cur_addr  <= cfg_acr;
      cur_count <= cfg_wtc;
    end else if (dreq_take) begin
      // One 32-bit word per request
      cur_addr  <= cur_addr + 32'd4;
      cur_count <= cur_count - 32'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= st_idle;
      started <= 1'b0;
      int_p   <= 1'b0;
      tc      <= 1'b0;
      fe_flg  <= 1'b0;
      dma_ack <= 1'b0;
      flush   <= 1'b0;
    end else begin
      // Ack follows the accepted request by one cycle
      dma_ack <= dreq_take;
      // Flush only honoured in the SCSI to memory direction
      flush   <= (act == act_flush) && cfg_cntr.dmadir;
      case (act)
        act_start: begin
          started <= 1'b1;
          if (cfg_wtc == '0) begin
            // Nothing to move, terminal count at once
            state <= st_done;
            tc    <= 1'b1;
            int_p <= 1'b1;
          end else begin
            state <= st_run;
          end
        end
        act_stop:    state <= st_idle;
        act_flush: begin
          if (cfg_cntr.dmadir) begin
            fe_flg <= 1'b1;
          end
        end
        act_clr_int: begin
          int_p  <= 1'b0;
          tc     <= 1'b0;
          fe_flg <= 1'b0;
        end
        default:     ;
      endcase
      // Terminal count beats a clear in the same cycle
      if (last_word) begin
        state <= st_done;
        tc    <= 1'b1;
        int_p <= 1'b1;
      end
    end
  end

  // Interrupt line is a level gated by the enable bit
  assign irq = int_p && cfg_cntr.intena;

  always_comb begin
    status          = '0;
    status.int_p    = int_p;
    status.dma_run  = (state == st_run);
    status.tc       = tc;
    status.fe_flg   = fe_flg;
  end

  // Count never wraps below zero
  assert property (@(posedge clk) disable iff (!rst_n)
    dreq_take |=> (($past(cur_count) != '0) && (cur_count == $past(cur_count) - 32'd1)))
    else $error("word count decremented at zero");

  // Flush pulse needs the direction bit the cycle before
  assert property (@(posedge clk) disable iff (!rst_n)
    flush |-> $past(cfg_cntr.dmadir))
    else $error("flush without dmadir");

endmodule

`default_nettype wire

//--- verilog/sdmac_top.sv
// SDMAC top level joining the address decoder, register block and DMA controller
`timescale 1ns/100ps
`default_nettype none

module sdmac_top
  import sdmac_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  bus_req_t          bus_req,
  input  logic              scsi_dreq,
  output logic [data_w-1:0] rdata,
  output logic              rd_valid,
  output logic              wd_cs,
  output logic [data_w-1:0] dma_addr,
  output logic              dma_ack,
  output logic              irq,
  output logic              flush
);

  dec_t              dec;
  cntr_t             cfg_cntr;
  logic [data_w-1:0] cfg_acr;
  logic [data_w-1:0] cfg_wtc;
  istr_t             status;
  logic [data_w-1:0] cur_count;
  logic              started;

  // Combinational decode of the CPU access
  sdmac_addr_decoder dec_i (
    .req   (bus_req),
    .dec   (dec),
    .wd_cs (wd_cs)
  );

  // Configuration and read back
  sdmac_regs regs_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .dec       (dec),
    .status    (status),
    .cur_addr  (dma_addr),
    .cur_count (cur_count),
    .started   (started),
    .cfg_cntr  (cfg_cntr),
    .cfg_acr   (cfg_acr),
    .cfg_wtc   (cfg_wtc),
    .rdata     (rdata),
    .rd_valid  (rd_valid)
  );

  // Working address doubles as the DMA address output
  sdmac_dma_ctrl dma_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .act       (dec.act),
    .cfg_cntr  (cfg_cntr),
    .cfg_acr   (cfg_acr),
    .cfg_wtc   (cfg_wtc),
    .scsi_dreq (scsi_dreq),
    .status    (status),
    .cur_addr  (dma_addr),
    .cur_count (cur_count),
    .started   (started),
    .dma_ack   (dma_ack),
    .irq       (irq),
    .flush     (flush)
  );

endmodule

`default_nettype wire

//--- sim/sdmac_tb.sv
// SDMAC testbench running register, DMA and flush steps from a test data file
`timescale 1ns/100ps
`default_nettype none

module sdmac_tb
  import sdmac_pkg::*;
();

  localparam int max_steps = 64;

  logic              clk;
  logic              rst_n;
  bus_req_t          bus_req;
  logic              scsi_dreq;
  logic [data_w-1:0] rdata;
  logic              rd_valid;
  logic              wd_cs;
  logic [data_w-1:0] dma_addr;
  logic              dma_ack;
  logic              irq;
  logic              flush;

  // One entry per data line
  logic [7:0]        ops   [0:max_steps-1];
  logic [8*16-1:0]   names [0:max_steps-1];
  logic [addr_w-1:0] offs  [0:max_steps-1];
  logic [data_w-1:0] datas [0:max_steps-1];
  logic [data_w-1:0] exps  [0:max_steps-1];

  int   n_steps = 0;
  int   cycles = 0;
  int   limit = 1000;
  int   ack_count = 0;
  logic cs_seen;

  // Expected working address from the last ACR write and the accepted requests
  logic [data_w-1:0] acr_model = '0;
  logic [data_w-1:0] addr_model = '0;

  sdmac_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus_req   (bus_req),
    .scsi_dreq (scsi_dreq),
    .rdata     (rdata),
    .rd_valid  (rd_valid),
    .wd_cs     (wd_cs),
    .dma_addr  (dma_addr),
    .dma_ack   (dma_ack),
    .irq       (irq),
    .flush     (flush)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%0s", why);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  // Cycle budget that is set once the data file is loaded
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      abort_run("timeout, the test steps did not finish in time");
    end
  end

  // Acks counted mid cycle where they are stable
  always @(negedge clk) begin
    if (dma_ack) begin
      ack_count = ack_count + 1;
    end
  end

  task automatic check(input string name, input logic [data_w-1:0] exp,
                       input logic [data_w-1:0] act);
    if (exp !== act) begin
      abort_run($sformatf("MISMATCH %0s expected %h actual %h", name, exp, act));
    end
  endtask

  // One strobe cycle with wd_cs sampled while the strobe is up
  task automatic bus_access(input logic rw, input logic [addr_w-1:0] addr,
                            input logic [data_w-1:0] data);
    @(posedge clk);
    bus_req <= '{strobe: 1'b1, rw: rw, addr: addr, wdata: data};
    @(negedge clk);
    cs_seen = wd_cs;
    @(posedge clk);
    bus_req <= '0;
  endtask

  // Read data is due exactly one cycle after the strobe and lasts one cycle
  task automatic read_reg(input int i);
    bus_access(1'b1, offs[i], '0);
    @(negedge clk);
    if (!rd_valid) begin
      abort_run($sformatf("no read data one cycle after the strobe of step %0s",
                          string'(names[i])));
    end
    check(string'(names[i]), exps[i], rdata);
    @(negedge clk);
    check(string'(names[i]), '0, rd_valid);
  endtask

  // N request pulses spaced two cycles apart
  task automatic dreq_burst(input int n);
    ack_count = 0;
    repeat (n) begin
      @(posedge clk);
      scsi_dreq <= 1'b1;
      @(posedge clk);
      scsi_dreq <= 1'b0;
    end
    // Last ack comes one cycle after the last request
    repeat (2) @(negedge clk);
  endtask

  initial begin
    int             fd;
    int             rc;
    logic [8*8-1:0] tok;
    logic [8*80-1:0] line;
    rst_n     = 1'b0;
    bus_req   = '0;
    scsi_dreq = 1'b0;
    cs_seen   = 1'b0;
    fd = $fopen("sim/sdmac_testdata.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open the test data file sim/sdmac_testdata.txt");
    end
    // Lines starting with # are comments
    rc = $fscanf(fd, "%s", tok);
    while (rc == 1) begin
      if (tok == "#") begin
        rc = $fgets(line, fd);
      end else begin
        if (n_steps >= max_steps) begin
          abort_run("too many lines in the test data file");
        end
        ops[n_steps] = tok[7:0];
        rc = $fscanf(fd, "%s %h %h %h", names[n_steps], offs[n_steps],
                     datas[n_steps], exps[n_steps]);
        if (rc != 4) begin
          abort_run("malformed line in the test data file");
        end
        n_steps++;
      end
      rc = $fscanf(fd, "%s", tok);
    end
    $fclose(fd);
    limit = 20 * n_steps + 100;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < n_steps; i++) begin
      case (ops[i])
        "W": begin
          bus_access(1'b0, offs[i], datas[i]);
          // A start loads the configured start address
          if (offs[i] == off_acr) begin
            acr_model = datas[i];
          end else if (offs[i] == off_st_dma) begin
            addr_model = acr_model;
          end
        end
        "R": read_reg(i);
        "D": begin
          dreq_burst(datas[i]);
          check(string'(names[i]), exps[i], ack_count);
          // Each accepted request moves the address on by one word
          addr_model = addr_model + 32'd4 * exps[i];
          check(string'(names[i]), addr_model, dma_addr);
        end
        // Flush pulse expected in the cycle after the strobe
        "F": begin
          bus_access(1'b0, offs[i], datas[i]);
          @(negedge clk);
          check(string'(names[i]), exps[i], flush);
        end
        "P": begin
          bus_access(1'b0, offs[i], datas[i]);
          check(string'(names[i]), exps[i], cs_seen);
        end
        "I": begin
          @(negedge clk);
          check(string'(names[i]), exps[i], irq);
        end
        default: abort_run("unknown operation in the test data file");
      endcase
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/sdmac_testdata.txt
# op name offset data expected, all numbers hex
# W write, R read, D dreq pulses and acks, F flush, P SCSI chip select, I irq
W cntr_wr 08 00000040 0
W acr_wr 0C 00001000 0
W wtc_wr 04 00000003 0
W dawr_wr 00 fffffffe 0
R cntr_rd 08 0 00000040
R acr_rd 0C 0 00001000
R wtc_rd 04 0 00000003
R dawr_rd 00 0 00000002
R unused_rd 20 0 00000000
P wd_write 40 deadbeef 1
R acr_after_wd 0C 0 00001000
R cntr_after_wd 08 0 00000040
W start_1 10 0 0
D dreq_1 00 3 3
R acr_tc 0C 0 0000100c
R wtc_tc 04 0 00000000
R istr_tc 1C 0 000000a0
I irq_on 00 0 1
W clr_int_1 18 0 0
I irq_off 00 0 0
R istr_clr 1C 0 00000000
W cntr_noint 08 0 0
W wtc_2 04 2 0
W start_2 10 0 0
D dreq_2 00 2 2
I irq_masked 00 0 0
W clr_int_2 18 0 0
W wtc_5 04 5 0
W start_3 10 0 0
D dreq_3 00 2 2
W stop 3C 0 0
D dreq_stopped 00 2 0
R acr_stop 0C 0 00001008
R wtc_stop 04 0 00000003
F flush_off 14 0 0
R istr_no_fe 1C 0 00000000
W cntr_dir 08 80 0
F flush_on 14 0 1
R istr_fe 1C 0 00000010

//--- files.f
verilog/sdmac_pkg.sv
verilog/sdmac_addr_decoder.sv
verilog/sdmac_regs.sv
verilog/sdmac_dma_ctrl.sv
verilog/sdmac_top.sv
sim/sdmac_tb.sv
